/* Makefile */
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = tb_mips_lite
FILELIST   = mips_lite.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* mips_lite.f */
src/mips_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_lite_top.sv
sim/mips_lite_sva.sv
sim/retire_checker.sv
sim/tb_mips_lite.sv

/* sim/mips_lite_sva.sv */
`timescale 1ns/100ps

module mips_lite_sva import mips_pkg::*; (
    input logic    i_clk,
    input logic    i_rst,
    input wb_req_t i_wb,
    input wb_rsp_t i_wb_rsp,
    input retire_t i_retire
);

    int fail_count = 0;

    // ----------------------------------------
    // Wishbone loader port
    // ----------------------------------------

    // Ack only inside an open request, and never in its first cycle
    a_ack_in_cycle: assert property (@(posedge i_clk)
        i_wb_rsp.ack |-> (i_wb.cyc && i_wb.stb && $past(i_wb.cyc && i_wb.stb)))
    else begin
        fail_count++;
        $error("ack raised outside an open Wishbone cycle");
    end

    // One edge of reset is enough to clear ack
    a_ack_reset: assert property (@(posedge i_clk) !i_rst |=> !i_wb_rsp.ack)
    else begin
        fail_count++;
        $error("ack high while reset is applied");
    end

    // ----------------------------------------
    // Retire port
    // ----------------------------------------
    a_retire_dest: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_retire.valid |-> (i_retire.dest != '0))
    else begin
        fail_count++;
        $error("retire reported for register 0");
    end

    a_retire_known: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_retire.valid |-> !$isunknown(i_retire.value))
    else begin
        fail_count++;
        $error("retire value has unknown bits");
    end

endmodule

bind mips_lite_top mips_lite_sva sva0 (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_wb     (i_wb),
    .i_wb_rsp (o_wb),
    .i_retire (o_retire)
);

/* sim/retire_checker.sv */
`timescale 1ns/100ps

module retire_checker import mips_pkg::*; (
    input logic    i_clk,
    input logic    i_rst,
    input wb_req_t i_wb,
    input wb_rsp_t i_wb_rsp,
    input retire_t i_retire
);

    retire_t         exp_q [$];
    logic [XLEN-1:0] read_q [$];
    int              ack_count    = 0;
    int              test_checks  = 0;
    int              test_errors  = 0;
    int              total_tests  = 0;
    int              total_checks = 0;
    int              total_errors = 0;

    // ----------------------------------------
    // Expected values from the testbench
    // ----------------------------------------
    task automatic push_retire(input retire_t want);
        exp_q.push_back(want);
    endtask

    task automatic push_readback(input logic [XLEN-1:0] want);
        read_q.push_back(want);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    function automatic int errors();
        return total_errors;
    endfunction

    task automatic check_value(
        input string           name,
        input logic [XLEN-1:0] want,
        input logic [XLEN-1:0] got
    );
        test_checks++;
        if (got !== want) begin
            test_errors++;
            $display("ERROR %s expected 0x%h actual 0x%h", name, want, got);
        end
    endtask

    // ----------------------------------------
    // Compare process
    // ----------------------------------------

    // Retires arrive strictly in program order
    always @(posedge i_clk) begin
        retire_t want;
        if (i_rst && i_retire.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                test_errors++;
                $display("Unexpected retire to r%0d with value 0x%h",
                         i_retire.dest, i_retire.value);
            end else begin
                want = exp_q.pop_front();
                check_value("o_retire.dest", XLEN'(want.dest), XLEN'(i_retire.dest));
                check_value("o_retire.value", want.value, i_retire.value);
            end
        end
    end

    // Read data is valid with ack
    always @(posedge i_clk) begin
        if (i_rst && i_wb_rsp.ack === 1'b1) begin
            ack_count++;
            if (!i_wb.we) begin
                if (read_q.size() == 0) begin
                    test_errors++;
                    $display("Wishbone read acknowledged with no read outstanding");
                end else begin
                    check_value("o_wb.dat", read_q.pop_front(), i_wb_rsp.dat);
                end
            end
        end
    end

    task automatic end_test(input string name);
        if (exp_q.size() != 0) begin
            test_errors++;
            $display("%s is missing %0d expected retires", name, exp_q.size());
            exp_q.delete();
        end
        if (read_q.size() != 0) begin
            test_errors++;
            $display("%s is missing %0d Wishbone read acks", name, read_q.size());
            read_q.delete();
        end
        total_tests++;
        total_checks += test_checks;
        total_errors += test_errors;
        $display("%-20s %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic report_counts();
        $display("%0d tests, %0d checks, %0d errors", total_tests, total_checks, total_errors);
    endtask

endmodule

/* sim/tb_mips_lite.sv */
`timescale 1ns/100ps

module tb_mips_lite import mips_pkg::*; ();

    logic    i_clk = 1'b0;
    logic    i_rst;
    logic    i_run;
    wb_req_t i_wb;
    wb_rsp_t o_wb;
    retire_t o_retire;

    int              seed     = 32'h1579_b769;
    bit              hung     = 1'b0;
    int              prev_len = 0;
    logic [XLEN-1:0] prog     [IMEM_DEPTH];
    logic [XLEN-1:0] ref_regs [2**NB_REG_ADDR] = '{default: '0};
    logic [XLEN-1:0] ref_dmem [DMEM_DEPTH] = '{default: '0};
    retire_t         expected [$];

    mips_lite_top dut0 (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_run    (i_run),
        .i_wb     (i_wb),
        .o_wb     (o_wb),
        .o_retire (o_retire)
    );

    retire_checker chk0 (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wb     (i_wb),
        .i_wb_rsp (o_wb),
        .i_retire (o_retire)
    );

    always #50 i_clk = ~i_clk;

    // ----------------------------------------
    // Instruction encoding
    // ----------------------------------------
    function automatic logic [XLEN-1:0] encode_r(
        input logic [5:0] fn,
        input logic [4:0] rd,
        input logic [4:0] rs,
        input logic [4:0] rt
    );
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [XLEN-1:0] encode_i(
        input logic [5:0]  op,
        input logic [4:0]  rt,
        input logic [4:0]  rs,
        input logic [15:0] imm
    );
        return {op, rs, rt, imm};
    endfunction

    // ----------------------------------------
    // Reference model that runs one instruction at a time
    // ----------------------------------------
    function automatic void run_reference(input int len);
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] res;
        logic [4:0]      dest;
        logic            wr;
        for (int pc = 0; pc < len; pc++) begin
            instr = prog[pc];
            a     = ref_regs[instr[25:21]];
            b     = ref_regs[instr[20:16]];
            addr  = a + {{16{instr[15]}}, instr[15:0]};
            dest  = instr[20:16];
            wr    = 1'b1;
            res   = '0;
            case (instr[31:26])
                OP_RTYPE: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        FN_ADD:  res = a + b;
                        FN_SUB:  res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDI: res = addr;
                // Data memory is word addressed by bits 9 down to 2
                OP_LW:   res = ref_dmem[addr[9:2]];
                OP_SW: begin
                    ref_dmem[addr[9:2]] = b;
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != 5'd0) begin
                ref_regs[dest] = res;
                expected.push_back('{valid: 1'b1, dest: dest, value: res});
            end
        end
    endfunction

    // ----------------------------------------
    // Wishbone loader and program execution
    // ----------------------------------------
    task automatic wb_access(
        input logic                    we,
        input logic [NB_IMEM_ADDR-1:0] adr,
        input logic [XLEN-1:0]         dat
    );
        int waited;
        if (!hung) begin
            @(posedge i_clk);
            i_wb <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
            waited = 0;
            @(posedge i_clk);
            while (!o_wb.ack && waited < 8) begin
                @(posedge i_clk);
                waited++;
            end
            i_wb <= '0;
            if (!o_wb.ack) begin
                hung = 1'b1;
                $display("Wishbone access to word %0d was never acknowledged", adr);
            end
        end
    endtask

    task automatic load_program(input int len);
        for (int i = 0; i < len; i++) begin
            wb_access(1'b1, i[7:0], prog[i]);
        end
        // Leftover words of a longer earlier program go back to NOP
        for (int i = len; i < prev_len; i++) begin
            wb_access(1'b1, i[7:0], '0);
        end
        prev_len = len;
    endtask

    task automatic execute_program(input string name, input int len);
        int waited;
        load_program(len);
        if (!hung) begin
            expected.delete();
            run_reference(len);
            foreach (expected[i]) begin
                chk0.push_retire(expected[i]);
            end
            @(posedge i_clk);
            i_run <= 1'b1;
            waited = 0;
            @(negedge i_clk);
            while (chk0.pending() != 0 && waited < len + 40) begin
                @(negedge i_clk);
                waited++;
            end
            if (chk0.pending() != 0) begin
                hung = 1'b1;
                $display("%s stopped retiring with %0d results outstanding",
                         name, chk0.pending());
            end else begin
                // Pipeline depth plus margin so any extra retire shows up
                repeat (8) @(negedge i_clk);
            end
            @(posedge i_clk);
            i_run <= 1'b0;
        end
        chk0.end_test(name);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic check_reset_and_loading();
        int acks_before;
        @(negedge i_clk);
        chk0.check_value("o_retire.valid", '0, XLEN'(o_retire.valid));
        chk0.check_value("o_wb.ack", '0, XLEN'(o_wb.ack));
        acks_before = chk0.ack_count;
        for (int i = 0; i < 16; i++) begin
            prog[i] = $random(seed);
            wb_access(1'b1, i[7:0], prog[i]);
        end
        for (int i = 0; i < 16; i++) begin
            chk0.push_readback(prog[i]);
            wb_access(1'b0, i[7:0], '0);
        end
        @(negedge i_clk);
        chk0.check_value("o_wb.ack count", 32, chk0.ack_count - acks_before);
        prev_len = 16;
        chk0.end_test("reset_and_loading");
    endtask

    // Distance one and two dependencies on every R-type op
    task automatic run_alu_chains();
        prog[0] = encode_i(OP_ADDI, 5'd1, 5'd0, 16'd5);
        prog[1] = encode_i(OP_ADDI, 5'd2, 5'd0, 16'hfffd);
        prog[2] = encode_r(FN_ADD, 5'd3, 5'd1, 5'd2);
        prog[3] = encode_r(FN_SUB, 5'd4, 5'd3, 5'd1);
        prog[4] = encode_r(FN_AND, 5'd5, 5'd4, 5'd3);
        prog[5] = encode_r(FN_OR,  5'd6, 5'd5, 5'd4);
        // Positive against negative, both ways round
        prog[6] = encode_r(FN_SLT, 5'd7, 5'd3, 5'd6);
        prog[7] = encode_r(FN_SLT, 5'd8, 5'd6, 5'd3);
        prog[8] = encode_r(FN_ADD, 5'd9, 5'd7, 5'd8);
        prog[9] = encode_r(FN_SUB, 5'd9, 5'd9, 5'd4);
        execute_program("alu_chains", 10);
    endtask

    task automatic run_addi_signs();
        prog[0] = encode_i(OP_ADDI, 5'd1, 5'd0, 16'hffff);
        prog[1] = encode_i(OP_ADDI, 5'd2, 5'd1, 16'h7fff);
        prog[2] = encode_i(OP_ADDI, 5'd3, 5'd2, 16'h8000);
        // r0 stays zero and retires nothing
        prog[3] = encode_i(OP_ADDI, 5'd0, 5'd1, 16'h0005);
        prog[4] = encode_i(OP_ADDI, 5'd4, 5'd0, 16'h007b);
        prog[5] = encode_i(OP_ADDI, 5'd5, 5'd3, 16'hfff0);
        execute_program("addi_signs", 6);
    endtask

    task automatic run_store_load();
        prog[0]  = encode_i(OP_ADDI, 5'd1, 5'd0, 16'h1234);
        prog[1]  = encode_i(OP_ADDI, 5'd2, 5'd0, 16'h0040);
        prog[2]  = encode_i(OP_SW,   5'd1, 5'd2, 16'd8);
        prog[3]  = encode_i(OP_ADDI, 5'd3, 5'd0, 16'h0007);
        prog[4]  = encode_i(OP_SW,   5'd3, 5'd2, 16'd12);
        prog[5]  = encode_i(OP_LW,   5'd4, 5'd2, 16'd8);
        prog[6]  = '0;
        prog[7]  = encode_r(FN_ADD, 5'd5, 5'd4, 5'd4);
        prog[8]  = encode_i(OP_LW,   5'd6, 5'd2, 16'd12);
        prog[9]  = '0;
        prog[10] = encode_i(OP_SW,   5'd5, 5'd0, 16'd0);
        prog[11] = encode_i(OP_LW,   5'd7, 5'd0, 16'd0);
        prog[12] = '0;
        execute_program("store_load", 13);
    endtask

    // Registers r0 to r7 only, so dependencies are dense
    task automatic run_random_program(input int n_words);
        logic [XLEN-1:0] r;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      rd;
        int              len;
        len = 0;
        while (len < n_words) begin
            r  = $random(seed);
            rs = {2'b00, r[2:0]};
            rt = {2'b00, r[5:3]};
            rd = {2'b00, r[8:6]};
            case (r[11:9])
                3'd0: prog[len] = encode_r(FN_ADD, rd, rs, rt);
                3'd1: prog[len] = encode_r(FN_SUB, rd, rs, rt);
                3'd2: prog[len] = encode_r(FN_AND, rd, rs, rt);
                3'd3: prog[len] = encode_r(FN_OR,  rd, rs, rt);
                3'd4: prog[len] = encode_r(FN_SLT, rd, rs, rt);
                3'd5: prog[len] = encode_i(OP_ADDI, rt, rs, r[31:16]);
                3'd6: begin
                    if (len < n_words - 1) begin
                        prog[len] = encode_i(OP_LW, rt, rs, r[31:16]);
                        // No hazard unit, so the load is always followed by a NOP
                        len++;
                        prog[len] = '0;
                    end else begin
                        prog[len] = encode_i(OP_ADDI, rt, rs, r[31:16]);
                    end
                end
                default: prog[len] = encode_i(OP_SW, rt, rs, r[31:16]);
            endcase
            len++;
        end
        execute_program("random_program", n_words);
    endtask

    // ----------------------------------------
    // Sequence
    // ----------------------------------------
    initial begin
        i_rst = 1'b0;
        i_run = 1'b0;
        i_wb  = '0;
        @(posedge i_clk);
        // A read request held open through reset must stay unacknowledged
        i_wb <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: '0, dat: '0};
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b1;
        i_wb  <= '0;
        check_reset_and_loading();
        run_alu_chains();
        run_addi_signs();
        run_store_load();
        run_random_program(200);
        @(negedge i_clk);
        chk0.report_counts();
        if (hung || chk0.errors() != 0 || dut0.sva0.fail_count != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage import mips_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic [XLEN-1:0] i_instr,
    input  retire_t         i_retire,
    output id_ex_t          o_id_ex
);

    logic [XLEN-1:0]        regs [2**NB_REG_ADDR];
    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [NB_REG_ADDR-1:0] rs;
    logic [NB_REG_ADDR-1:0] rt;
    logic [NB_REG_ADDR-1:0] rd;
    logic [XLEN-1:0]        rs_val;
    logic [XLEN-1:0]        rt_val;
    ctrl_t                  ctrl;
    id_ex_t                 id_ex_d;
    id_ex_t                 id_ex_q;

    assign opcode = i_instr[31:26];
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign funct  = i_instr[5:0];

    // ----------------------------------------
    // Register file
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            for (int i = 0; i < 2**NB_REG_ADDR; i++) begin
                regs[i] <= '0;
            end
        end else if (i_retire.valid) begin
            regs[i_retire.dest] <= i_retire.value;
        end
    end

    // r0 is hardwired, a write in flight this cycle is passed through
    function automatic logic [XLEN-1:0] read_reg(input logic [NB_REG_ADDR-1:0] idx);
        logic [XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (i_retire.valid && i_retire.dest == idx) begin
            val = i_retire.value;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    assign rs_val = read_reg(rs);
    assign rt_val = read_reg(rt);

    // ----------------------------------------
    // Control decoder
    // ----------------------------------------
    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // ----------------------------------------
    // ID/EX register
    // ----------------------------------------
    always_comb begin
        id_ex_d.ctrl   = ctrl;
        id_ex_d.rs_val = rs_val;
        id_ex_d.rt_val = rt_val;
        id_ex_d.imm    = {{(XLEN-16){i_instr[15]}}, i_instr[15:0]};
        id_ex_d.rs     = rs;
        id_ex_d.rt     = rt;
        // No destination unless the instruction writes a register
        if (!ctrl.reg_write) begin
            id_ex_d.dest = '0;
        end else if (opcode == OP_RTYPE) begin
            id_ex_d.dest = rd;
        end else begin
            id_ex_d.dest = rt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign o_id_ex = id_ex_q;

endmodule

/* src/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import mips_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst,
    input  id_ex_t  i_id_ex,
    input  retire_t i_retire,
    output ex_mem_t o_ex_mem
);

    ex_mem_t         ex_mem_d;
    ex_mem_t         ex_mem_q;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rt_fwd;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;

    // ----------------------------------------
    // Forwarding
    // ----------------------------------------

    // EX/MEM is newer than MEM/WB and wins
    function automatic fwd_sel_e pick_src(input logic [NB_REG_ADDR-1:0] idx);
        fwd_sel_e sel;
        sel = FWD_REG;
        if (idx != '0) begin
            if (ex_mem_q.ctrl.reg_write && ex_mem_q.dest == idx) begin
                sel = FWD_EX_MEM;
            end else if (i_retire.valid && i_retire.dest == idx) begin
                sel = FWD_MEM_WB;
            end
        end
        return sel;
    endfunction

    function automatic logic [XLEN-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] reg_val
    );
        logic [XLEN-1:0] val;
        case (sel)
            FWD_EX_MEM: val = ex_mem_q.alu_result;
            FWD_MEM_WB: val = i_retire.value;
            default:    val = reg_val;
        endcase
        return val;
    endfunction

    assign fwd_a  = pick_src(i_id_ex.rs);
    assign fwd_b  = pick_src(i_id_ex.rt);
    assign op_a   = fwd_mux(fwd_a, i_id_ex.rs_val);
    assign rt_fwd = fwd_mux(fwd_b, i_id_ex.rt_val);
    assign op_b   = i_id_ex.ctrl.alu_src ? i_id_ex.imm : rt_fwd;

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_result = '0;
        endcase
    end

    // EX/MEM register, store data is the forwarded rt
    assign ex_mem_d = '{
        ctrl:       i_id_ex.ctrl,
        alu_result: alu_result,
        store_data: rt_fwd,
        dest:       i_id_ex.dest
    };

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q <= ex_mem_d;
        end
    end

    assign o_ex_mem = ex_mem_q;

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage import mips_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_run,
    input  wb_req_t         i_wb,
    output wb_rsp_t         o_wb,
    output logic [XLEN-1:0] o_instr
);

    // Power-up contents are zero, so unloaded words fetch as NOP
    logic [XLEN-1:0]         imem [IMEM_DEPTH] = '{default: '0};
    logic [NB_IMEM_ADDR-1:0] pc;
    logic [XLEN-1:0]         if_id_instr;
    logic                    wb_ack;
    logic                    wb_start;
    logic [XLEN-1:0]         wb_rd_data;

    // ----------------------------------------
    // Wishbone loader port
    // ----------------------------------------

    // First cycle of an access, before ack is up
    assign wb_start = i_wb.cyc && i_wb.stb && !wb_ack;

    // Ack follows the request by one cycle and holds while stb stays high
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= i_wb.cyc && i_wb.stb;
        end
    end

    always_ff @(posedge i_clk) begin
        // Program loads only while the core is held
        if (wb_start && i_wb.we && !i_run) begin
            imem[i_wb.adr] <= i_wb.dat;
        end
        if (wb_start) begin
            wb_rd_data <= imem[i_wb.adr];
        end
    end

    // Ack drops together with stb
    assign o_wb = '{
        ack: wb_ack && i_wb.cyc && i_wb.stb,
        dat: wb_rd_data
    };

    // ----------------------------------------
    // PC and IF/ID register
    // ----------------------------------------

    // First edge with i_run high captures word 0
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            pc          <= '0;
            if_id_instr <= '0;
        end else if (i_run) begin
            pc          <= pc + 1'b1;
            if_id_instr <= imem[pc];
        end else begin
            pc          <= '0;
            if_id_instr <= '0;
        end
    end

    assign o_instr = if_id_instr;

endmodule

/* src/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage import mips_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst,
    input  ex_mem_t i_ex_mem,
    output retire_t o_retire
);

    logic [XLEN-1:0]         dmem [DMEM_DEPTH] = '{default: '0};
    logic [NB_DMEM_ADDR-1:0] dmem_addr;
    logic [XLEN-1:0]         load_data;
    retire_t                 retire_d;
    retire_t                 retire_q;

    // ----------------------------------------
    // Data memory
    // ----------------------------------------

    // Word address from the byte address
    assign dmem_addr = i_ex_mem.alu_result[NB_DMEM_ADDR+1:2];

    always_ff @(posedge i_clk) begin
        if (i_ex_mem.ctrl.mem_write) begin
            dmem[dmem_addr] <= i_ex_mem.store_data;
        end
    end

    assign load_data = i_ex_mem.ctrl.mem_read ? dmem[dmem_addr] : '0;

    // ----------------------------------------
    // MEM/WB register and write-back select
    // ----------------------------------------
    always_comb begin
        retire_d.valid = i_ex_mem.ctrl.reg_write && (i_ex_mem.dest != '0);
        retire_d.dest  = i_ex_mem.dest;
        if (i_ex_mem.ctrl.mem_to_reg) begin
            retire_d.value = load_data;
        end else begin
            retire_d.value = i_ex_mem.alu_result;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            retire_q <= '0;
        end else begin
            retire_q <= retire_d;
        end
    end

    // Feeds the register file, forwarding and the retire port
    assign o_retire = retire_q;

endmodule

/* src/mips_lite_top.sv */
`timescale 1ns/100ps

module mips_lite_top import mips_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_run,
    input  wb_req_t i_wb,
    output wb_rsp_t o_wb,
    output retire_t o_retire
);

    // ----------------------------------------
    // Stage to stage payloads
    // ----------------------------------------
    logic [XLEN-1:0] if_id_instr;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    retire_t         mem_wb;

    // Fetch, with the program loader
    fetch_stage u_fetch_stage (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_run   (i_run),
        .i_wb    (i_wb),
        .o_wb    (o_wb),
        .o_instr (if_id_instr)
    );

    decode_stage u_decode_stage (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_instr  (if_id_instr),
        .i_retire (mem_wb),
        .o_id_ex  (id_ex)
    );

    execute_stage u_execute_stage (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_id_ex  (id_ex),
        .i_retire (mem_wb),
        .o_ex_mem (ex_mem)
    );

    memory_stage u_memory_stage (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_ex_mem (ex_mem),
        .o_retire (mem_wb)
    );

    assign o_retire = mem_wb;

endmodule

/* src/mips_pkg.sv */
package mips_pkg;

    // ----------------------------------------
    // Widths and memory sizes
    // ----------------------------------------
    localparam int XLEN         = 32;
    localparam int NB_REG_ADDR  = 5;
    localparam int IMEM_DEPTH   = 256;
    localparam int DMEM_DEPTH   = 256;
    localparam int NB_IMEM_ADDR = 8;
    localparam int NB_DMEM_ADDR = 8;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct field
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // Where an ALU operand comes from
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_e;

    // ----------------------------------------
    // Pipeline payloads
    // ----------------------------------------
    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [XLEN-1:0]        rs_val;
        logic [XLEN-1:0]        rt_val;
        logic [XLEN-1:0]        imm;
        logic [NB_REG_ADDR-1:0] rs;
        logic [NB_REG_ADDR-1:0] rt;
        logic [NB_REG_ADDR-1:0] dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [XLEN-1:0]        alu_result;
        logic [XLEN-1:0]        store_data;
        logic [NB_REG_ADDR-1:0] dest;
    } ex_mem_t;

    // One register write leaving the pipe
    typedef struct packed {
        logic                   valid;
        logic [NB_REG_ADDR-1:0] dest;
        logic [XLEN-1:0]        value;
    } retire_t;

    // Wishbone classic, loader side of instruction memory
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [NB_IMEM_ADDR-1:0] adr;
        logic [XLEN-1:0]         dat;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_rsp_t;

endpackage
